//--- common/ecc_pkg.sv
package ecc_pkg;

  localparam int DATA_W  = 32;
  localparam int CHECK_W = 7;
  localparam int CODE_W  = DATA_W + CHECK_W;

  typedef logic [CHECK_W-1:0][CODE_W-1:0] h_rows_t;

  // Check bits sit above the data bits in the flat view.
  typedef struct packed {
    logic [CHECK_W-1:0] check;
    logic [DATA_W-1:0]  data;
  } codeword_s;

  typedef union packed {
    logic [CODE_W-1:0] flat;
    codeword_s         fields;
  } codeword_u;

  typedef struct packed {
    logic single;    // Correctable error seen.
    logic multiple;  // Uncorrectable error seen.
  } ecc_status_t;

  // Hsiao columns: the first DATA_W weight-3 patterns in ascending order,
  // then one unit vector per check bit.
  function automatic h_rows_t build_h_rows();
    h_rows_t            rows;
    logic [CHECK_W-1:0] pat;
    int                 col;
    int                 ones;
    rows = '0;
    col  = 0;
    for (int v = 0; v < 2**CHECK_W; v++) begin
      pat  = v[CHECK_W-1:0];
      ones = 0;
      for (int b = 0; b < CHECK_W; b++) begin
        ones += int'(pat[b]);
      end
      if (ones == 3 && col < DATA_W) begin
        for (int b = 0; b < CHECK_W; b++) begin
          rows[b][col] = pat[b];
        end
        col++;
      end
    end
    for (int m = 0; m < CHECK_W; m++) begin
      rows[m][DATA_W+m] = 1'b1;
    end
    return rows;
  endfunction

  localparam h_rows_t H_ROWS = build_h_rows();

endpackage

//--- common/axil_pkg.sv
package axil_pkg;

  localparam int AXIL_ADDR_W = 32;
  localparam int AXIL_DATA_W = 32;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Everything the master drives.
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] awaddr;
    logic                   awvalid;
    logic [AXIL_DATA_W-1:0] wdata;
    logic                   wvalid;
    logic                   bready;
    logic [AXIL_ADDR_W-1:0] araddr;
    logic                   arvalid;
    logic                   rready;
  } axil_req_t;

  // Everything the slave drives.
  typedef struct packed {
    logic                   awready;
    logic                   wready;
    logic                   bvalid;
    resp_t                  bresp;
    logic                   arready;
    logic                   rvalid;
    logic [AXIL_DATA_W-1:0] rdata;
    resp_t                  rresp;
  } axil_rsp_t;

endpackage

//--- ecc/ecc_encode.sv
`timescale 1ns/10ps

module ecc_encode (
  input  logic [ecc_pkg::DATA_W-1:0] data,
  output ecc_pkg::codeword_u         code
);
  import ecc_pkg::*;

  logic [CHECK_W-1:0] check;

  // Each check bit covers the data columns of its H row.
  for (genvar m = 0; m < CHECK_W; m++) begin : g_check
    assign check[m] = ^(data & H_ROWS[m][DATA_W-1:0]);
  end

  always_comb begin
    code.fields.data  = data;
    code.fields.check = check;
  end

endmodule

//--- ecc/ecc_dec_fix.sv
`timescale 1ns/10ps

module ecc_dec_fix (
  input  logic                       clk,
  input  logic                       rst_n,
  input  ecc_pkg::codeword_u         rd_code,
  input  logic                       rd_en,
  input  logic                       correct_en,
  output logic [ecc_pkg::DATA_W-1:0] rd_data,
  output ecc_pkg::ecc_status_t       status
);
  import ecc_pkg::*;

  logic [CHECK_W-1:0] syndrome_ns;
  logic [CHECK_W-1:0] syndrome_r;
  logic [DATA_W-1:0]  payload_r;
  logic [DATA_W-1:0]  flip_bits;
  logic               code_valid;    // Aligned with rd_code.
  logic               status_valid;  // Aligned with syndrome_r.
  logic               syn_zero;
  logic               syn_odd;

  ////////////////////////////////////////////////////////////
  // Syndrome stage
  ////////////////////////////////////////////////////////////

  for (genvar m = 0; m < CHECK_W; m++) begin : g_syn
    assign syndrome_ns[m] = ^(rd_code.flat & H_ROWS[m]);
  end

  always_ff @(posedge clk) begin
    syndrome_r <= syndrome_ns;
    payload_r  <= rd_code.fields.data;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid   <= 1'b0;
      status_valid <= 1'b0;
    end else begin
      code_valid   <= rd_en;
      status_valid <= code_valid;
    end
  end

  ////////////////////////////////////////////////////////////
  // Correction
  ////////////////////////////////////////////////////////////

  // A data bit flips when its H column equals the syndrome.
  for (genvar n = 0; n < DATA_W; n++) begin : g_flip
    logic [CHECK_W-1:0] h_col;
    for (genvar p = 0; p < CHECK_W; p++) begin : g_bit
      assign h_col[p] = H_ROWS[p][n];
    end
    assign flip_bits[n] = (h_col == syndrome_r);
  end

  assign rd_data = correct_en ? (payload_r ^ flip_bits) : payload_r;

  // Odd weight means one bit in error, even nonzero means two or more.
  assign syn_zero = ~|syndrome_r;
  assign syn_odd  = ^syndrome_r;

  always_comb begin
    status.single   = status_valid && !syn_zero && syn_odd;
    status.multiple = status_valid && !syn_zero && !syn_odd;
  end

endmodule

//--- design/ecc_ram.sv
`timescale 1ns/10ps

module ecc_ram #(
  parameter int ADDR_BITS = 6
) (
  input  logic                       clk,
  input  logic                       we,
  input  logic                       re,
  input  logic [ADDR_BITS-1:0]       addr,
  input  ecc_pkg::codeword_u         wr_code,
  input  logic [ecc_pkg::CODE_W-1:0] inject_mask,
  output ecc_pkg::codeword_u         rd_code
);
  import ecc_pkg::*;

  localparam int DEPTH = 2**ADDR_BITS;

  codeword_u mem [DEPTH];

  // Injected faults are stored, so every later read sees them.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr].flat <= wr_code.flat ^ inject_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (re) begin
      rd_code <= mem[addr];  // Holds until the next read.
    end
  end

endmodule

//--- design/axil_ecc_ctrl.sv
`timescale 1ns/10ps

module axil_ecc_ctrl #(
  parameter int ADDR_BITS = 6
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  axil_pkg::axil_req_t        req,
  output axil_pkg::axil_rsp_t        rsp,
  output logic                       ram_we,
  output logic                       ram_re,
  output logic [ADDR_BITS-1:0]       ram_addr,
  output logic [ecc_pkg::DATA_W-1:0] wr_data,
  output logic [ecc_pkg::CODE_W-1:0] inject_mask,
  output logic                       correct_en,
  input  logic [ecc_pkg::DATA_W-1:0] rd_data,
  input  ecc_pkg::ecc_status_t       status
);
  import axil_pkg::*;
  import ecc_pkg::*;

  // Register index is byte address bits 4:2 inside the 0x1000 space.
  // INJECT holds mask bits 31:0, INJECT_HI the check-bit part of the mask.
  localparam logic [2:0] REG_CTRL      = 3'd0;
  localparam logic [2:0] REG_INJECT    = 3'd1;
  localparam logic [2:0] REG_SINGLE    = 3'd2;
  localparam logic [2:0] REG_MULTI     = 3'd3;
  localparam logic [2:0] REG_INJECT_HI = 3'd4;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_WAIT_RAM,
    RD_WAIT_DEC,
    RD_RESP
  } rd_state_e;

  function automatic logic reg_hit(logic [AXIL_ADDR_W-1:0] addr);
    return (addr[11:5] == '0) && (addr[4:2] <= REG_INJECT_HI);
  endfunction

  logic                   init_done;
  logic                   wr_hs;
  logic                   rd_hs;
  logic                   ar_ready;
  logic [2:0]             wr_reg;
  logic [2:0]             rd_reg;
  logic                   bvalid_q;
  resp_t                  bresp_q;
  rd_state_e              rd_state;
  logic [AXIL_DATA_W-1:0] rdata_q;
  resp_t                  rresp_q;
  logic [AXIL_DATA_W-1:0] reg_rdata;
  logic [AXIL_DATA_W-1:0] single_cnt;
  logic [AXIL_DATA_W-1:0] multi_cnt;
  logic [CODE_W-1:0]      inject_q;
  logic                   ctrl_q;

  ////////////////////////////////////////////////////////////
  // Handshakes and RAM port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) init_done <= 1'b0;
    else        init_done <= 1'b1;
  end

  assign wr_hs    = init_done && req.awvalid && req.wvalid && !bvalid_q;
  assign ar_ready = init_done && (rd_state == RD_IDLE) && !wr_hs;  // Write wins.
  assign rd_hs    = req.arvalid && ar_ready;

  assign wr_reg = req.awaddr[4:2];
  assign rd_reg = req.araddr[4:2];

  assign ram_we      = wr_hs && !req.awaddr[12];
  assign ram_re      = rd_hs && !req.araddr[12];
  assign ram_addr    = wr_hs ? req.awaddr[ADDR_BITS+1:2] : req.araddr[ADDR_BITS+1:2];
  assign wr_data     = req.wdata;
  assign inject_mask = inject_q;
  assign correct_en  = ctrl_q;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q   <= 1'b1;
      inject_q <= '0;
    end else if (wr_hs && req.awaddr[12] && reg_hit(req.awaddr)) begin
      case (wr_reg)
        REG_CTRL:      ctrl_q <= req.wdata[0];
        REG_INJECT:    inject_q[DATA_W-1:0] <= req.wdata;
        REG_INJECT_HI: inject_q[CODE_W-1:DATA_W] <= req.wdata[CHECK_W-1:0];
        default:       ;  // Counters are read-only.
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)         bvalid_q <= 1'b0;
    else if (wr_hs)     bvalid_q <= 1'b1;
    else if (req.bready) bvalid_q <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (wr_hs) begin
      bresp_q <= (req.awaddr[12] && !reg_hit(req.awaddr)) ? RESP_SLVERR : RESP_OKAY;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (rd_reg)
      REG_CTRL:      reg_rdata = {{(AXIL_DATA_W-1){1'b0}}, ctrl_q};
      REG_INJECT:    reg_rdata = inject_q[DATA_W-1:0];
      REG_SINGLE:    reg_rdata = single_cnt;
      REG_MULTI:     reg_rdata = multi_cnt;
      REG_INJECT_HI: reg_rdata = {{(AXIL_DATA_W-CHECK_W){1'b0}}, inject_q[CODE_W-1:DATA_W]};
      default:       reg_rdata = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= RD_IDLE;
    end else begin
      case (rd_state)
        RD_IDLE: begin
          if (rd_hs) rd_state <= req.araddr[12] ? RD_RESP : RD_WAIT_RAM;
        end
        RD_WAIT_RAM: rd_state <= RD_WAIT_DEC;
        RD_WAIT_DEC: rd_state <= RD_RESP;  // Decoder status is valid here.
        RD_RESP: begin
          if (req.rready) rd_state <= RD_IDLE;
        end
        default: rd_state <= RD_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_hs && req.araddr[12]) begin
      rdata_q <= reg_rdata;
      rresp_q <= reg_hit(req.araddr) ? RESP_OKAY : RESP_SLVERR;
    end else if (rd_state == RD_WAIT_DEC) begin
      rdata_q <= rd_data;
      rresp_q <= status.multiple ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Saturating error counters.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      single_cnt <= '0;
      multi_cnt  <= '0;
    end else if (rd_state == RD_WAIT_DEC) begin
      if (status.single && (single_cnt != '1))  single_cnt <= single_cnt + 1'b1;
      if (status.multiple && (multi_cnt != '1)) multi_cnt  <= multi_cnt + 1'b1;
    end
  end

  always_comb begin
    rsp.awready = wr_hs;
    rsp.wready  = wr_hs;
    rsp.bvalid  = bvalid_q;
    rsp.bresp   = bresp_q;
    rsp.arready = ar_ready;
    rsp.rvalid  = (rd_state == RD_RESP);
    rsp.rdata   = rdata_q;
    rsp.rresp   = rresp_q;
  end

endmodule

//--- design/ecc_mem_top.sv
`timescale 1ns/10ps

module ecc_mem_top #(
  parameter int ADDR_BITS = 6
) (
  input  logic                clk,
  input  logic                rst_n,
  input  axil_pkg::axil_req_t req,
  output axil_pkg::axil_rsp_t rsp
);
  import ecc_pkg::*;

  logic                 ram_we;
  logic                 ram_re;
  logic [ADDR_BITS-1:0] ram_addr;
  logic [DATA_W-1:0]    wr_data;
  logic [CODE_W-1:0]    inject_mask;
  logic                 correct_en;
  logic [DATA_W-1:0]    rd_data;
  ecc_status_t          status;
  codeword_u            wr_code;
  codeword_u            rd_code;

  axil_ecc_ctrl #(
    .ADDR_BITS (ADDR_BITS)
  ) u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .rsp         (rsp),
    .ram_we      (ram_we),
    .ram_re      (ram_re),
    .ram_addr    (ram_addr),
    .wr_data     (wr_data),
    .inject_mask (inject_mask),
    .correct_en  (correct_en),
    .rd_data     (rd_data),
    .status      (status)
  );

  ecc_encode u_enc (
    .data (wr_data),
    .code (wr_code)
  );

  ecc_ram #(
    .ADDR_BITS (ADDR_BITS)
  ) u_ram (
    .clk         (clk),
    .we          (ram_we),
    .re          (ram_re),
    .addr        (ram_addr),
    .wr_code     (wr_code),
    .inject_mask (inject_mask),
    .rd_code     (rd_code)
  );

  ecc_dec_fix u_dec (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_code    (rd_code),
    .rd_en      (ram_re),  // Delayed inside to line up with the syndrome.
    .correct_en (correct_en),
    .rd_data    (rd_data),
    .status     (status)
  );

endmodule

//--- test/tb_ecc_mem.sv
`timescale 1ns/10ps

module tb_ecc_mem;
  import axil_pkg::*;
  import ecc_pkg::*;

  localparam int ADDR_BITS = 6;
  localparam int TIMEOUT   = 100;
  localparam int CH_AW     = 0;
  localparam int CH_B      = 1;
  localparam int CH_AR     = 2;
  localparam int CH_R      = 3;

  localparam logic [31:0] A_CTRL      = 32'h1000;
  localparam logic [31:0] A_INJECT    = 32'h1004;
  localparam logic [31:0] A_SINGLE    = 32'h1008;
  localparam logic [31:0] A_MULTI     = 32'h100C;
  localparam logic [31:0] A_INJECT_HI = 32'h1010;

  logic      clk;
  logic      rst_n;
  axil_req_t req;
  axil_rsp_t rsp;

  int          errors;
  int          test_errs;
  int          tests_run;
  int          tests_failed;
  string       cur_name;
  logic [31:0] exp_single_cnt;  // Running totals from the vector file.
  logic [31:0] exp_multi_cnt;

  ecc_mem_top #(
    .ADDR_BITS (ADDR_BITS)
  ) dut0 (
    .clk   (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Bookkeeping and checks
  ////////////////////////////////////////////////////////////

  task automatic begin_test(input string name);
    cur_name  = name;
    test_errs = 0;
    tests_run++;
  endtask

  task automatic end_test();
    if (test_errs != 0) tests_failed++;
    $display("%-14s %s", cur_name, (test_errs == 0) ? "ok" : "FAILED");
  endtask

  task automatic check_word(input string what, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp)
    else begin
      $display("Error at %0t ns: %s in %s is %h, expected %h",
               $time, what, cur_name, got, exp);
      errors++;
      test_errs++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite driver
  ////////////////////////////////////////////////////////////

  function automatic logic chan_flag(input int chan);
    case (chan)
      CH_AW:   return rsp.awready;
      CH_B:    return rsp.bvalid;
      CH_AR:   return rsp.arready;
      default: return rsp.rvalid;
    endcase
  endfunction

  // Returns at the rising edge where the flag is seen high.
  task automatic wait_chan(input int chan, input string chan_name);
    int   cnt;
    logic seen;
    cnt  = 0;
    seen = 1'b0;
    while (!seen && cnt < TIMEOUT) begin
      @(posedge clk);
      seen = chan_flag(chan);
      cnt++;
    end
    if (!seen) begin
      $display("Timeout: the %s channel did not respond within %0d cycles at %0t ns",
               chan_name, TIMEOUT, $time);
      errors++;
      test_errs++;
    end
  endtask

  task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                            output resp_t resp);
    req.awaddr  <= addr;
    req.wdata   <= data;
    req.awvalid <= 1'b1;
    req.wvalid  <= 1'b1;
    req.bready  <= 1'b1;
    wait_chan(CH_AW, "write address");
    check_word("wready", 32'(rsp.wready), 32'd1);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    wait_chan(CH_B, "write response");
    resp = rsp.bresp;
    req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                           output resp_t resp);
    req.araddr  <= addr;
    req.arvalid <= 1'b1;
    req.rready  <= 1'b1;
    wait_chan(CH_AR, "read address");
    req.arvalid <= 1'b0;
    wait_chan(CH_R, "read data");
    data = rsp.rdata;
    resp = rsp.rresp;
    req.rready <= 1'b0;
  endtask

  task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
    resp_t resp;
    axil_write(addr, data, resp);
    check_word("bresp", 32'(resp), 32'(RESP_OKAY));
  endtask

  task automatic read_expect(input logic [31:0] addr, input logic [31:0] exp_data,
                             input resp_t exp_resp);
    logic [31:0] data;
    resp_t       resp;
    axil_read(addr, data, resp);
    check_word("rdata", data, exp_data);
    check_word("rresp", 32'(resp), 32'(exp_resp));
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic check_registers();
    resp_t resp;
    begin_test("reg_reset");
    read_expect(A_CTRL, 32'd1, RESP_OKAY);
    read_expect(A_INJECT, 32'd0, RESP_OKAY);
    read_expect(A_INJECT_HI, 32'd0, RESP_OKAY);
    read_expect(A_SINGLE, 32'd0, RESP_OKAY);
    read_expect(A_MULTI, 32'd0, RESP_OKAY);
    end_test();
    begin_test("reg_cnt_wr");
    write_ok(A_SINGLE, 32'h0000_0055);  // Ignored, answered OKAY.
    write_ok(A_MULTI, 32'hFFFF_FFFF);
    read_expect(A_SINGLE, 32'd0, RESP_OKAY);
    read_expect(A_MULTI, 32'd0, RESP_OKAY);
    end_test();
    begin_test("reg_unmapped");
    read_expect(32'h1014, 32'd0, RESP_SLVERR);
    axil_write(32'h1020, 32'h1234_5678, resp);
    check_word("bresp", 32'(resp), 32'(RESP_SLVERR));
    end_test();
  endtask

  task automatic run_vectors();
    int                fd;
    int                n;
    string             line;
    string             name;
    logic [CODE_W-1:0] mask;
    logic [31:0]       ce;
    logic [31:0]       addr;
    logic [31:0]       wdata;
    logic [31:0]       exp_data;
    logic [31:0]       exp_resp;
    logic [31:0]       exp_single;
    logic [31:0]       exp_multi;
    fd = $fopen("test/ecc_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file test/ecc_vectors.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h", name, mask, ce, addr, wdata,
                  exp_data, exp_resp, exp_single, exp_multi);
      if (n != 9) begin
        $display("Vector line could not be parsed: %s", line);
        errors++;
        continue;
      end
      begin_test(name);
      write_ok(A_CTRL, ce);
      write_ok(A_INJECT, mask[31:0]);
      write_ok(A_INJECT_HI, {25'd0, mask[CODE_W-1:32]});
      write_ok(addr, wdata);  // Mask is applied to this codeword.
      read_expect(addr, exp_data, resp_t'(exp_resp[1:0]));
      read_expect(A_SINGLE, exp_single, RESP_OKAY);
      read_expect(A_MULTI, exp_multi, RESP_OKAY);
      exp_single_cnt = exp_single;
      exp_multi_cnt  = exp_multi;
      end_test();
    end
    $fclose(fd);
  endtask

  task automatic random_round_trips(input int count);
    logic [31:0] addr;
    logic [31:0] data;
    begin_test("random_clean");
    write_ok(A_CTRL, 32'd1);
    write_ok(A_INJECT, 32'd0);
    write_ok(A_INJECT_HI, 32'd0);
    for (int i = 0; i < count; i++) begin
      addr = 32'($urandom_range(2**ADDR_BITS - 1, 0)) << 2;
      data = $urandom();
      write_ok(addr, data);
      read_expect(addr, data, RESP_OKAY);
    end
    read_expect(A_SINGLE, exp_single_cnt, RESP_OKAY);
    read_expect(A_MULTI, exp_multi_cnt, RESP_OKAY);
    end_test();
  endtask

  task automatic read_backpressure();
    logic [31:0] held;
    int          hold;
    begin_test("r_backpressure");
    write_ok(32'h0000_0040, 32'h1357_9BDF);
    write_ok(32'h0000_0044, 32'h2468_ACE0);
    hold = $urandom_range(20, 1);
    req.araddr  <= 32'h0000_0040;
    req.arvalid <= 1'b1;
    wait_chan(CH_AR, "read address");
    req.araddr <= 32'h0000_0044;  // Second AR stays pending.
    wait_chan(CH_R, "read data");
    held = rsp.rdata;
    check_word("rdata", held, 32'h1357_9BDF);
    repeat (hold) begin
      @(posedge clk);
      check_word("rvalid", 32'(rsp.rvalid), 32'd1);
      check_word("held rdata", rsp.rdata, held);
      check_word("arready", 32'(rsp.arready), 32'd0);
    end
    req.rready <= 1'b1;
    @(posedge clk);
    check_word("rvalid", 32'(rsp.rvalid), 32'd1);
    req.rready <= 1'b0;
    wait_chan(CH_AR, "read address");
    req.arvalid <= 1'b0;
    req.rready  <= 1'b1;
    wait_chan(CH_R, "read data");
    check_word("rdata", rsp.rdata, 32'h2468_ACE0);
    req.rready <= 1'b0;
    end_test();
  endtask

  task automatic write_backpressure();
    resp_t held;
    int    hold;
    begin_test("b_backpressure");
    hold = $urandom_range(20, 1);
    req.awaddr  <= 32'h0000_0080;
    req.wdata   <= 32'hA1B2_C3D4;
    req.awvalid <= 1'b1;
    req.wvalid  <= 1'b1;
    wait_chan(CH_AW, "write address");
    req.awaddr <= 32'h0000_0084;  // Second write stays pending.
    req.wdata  <= 32'h5E6F_7081;
    wait_chan(CH_B, "write response");
    held = rsp.bresp;
    check_word("bresp", 32'(held), 32'(RESP_OKAY));
    repeat (hold) begin
      @(posedge clk);
      check_word("bvalid", 32'(rsp.bvalid), 32'd1);
      check_word("held bresp", 32'(rsp.bresp), 32'(held));
      check_word("awready", 32'(rsp.awready), 32'd0);
      check_word("wready", 32'(rsp.wready), 32'd0);
    end
    req.bready <= 1'b1;
    @(posedge clk);
    check_word("bvalid", 32'(rsp.bvalid), 32'd1);
    req.bready <= 1'b0;
    wait_chan(CH_AW, "write address");
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    req.bready  <= 1'b1;
    wait_chan(CH_B, "write response");
    req.bready <= 1'b0;
    read_expect(32'h0000_0080, 32'hA1B2_C3D4, RESP_OKAY);
    read_expect(32'h0000_0084, 32'h5E6F_7081, RESP_OKAY);
    end_test();
  endtask

  initial begin
    void'($urandom(3121));
    errors         = 0;
    test_errs      = 0;
    tests_run      = 0;
    tests_failed   = 0;
    exp_single_cnt = '0;
    exp_multi_cnt  = '0;
    req            = '0;
    rst_n          = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    check_registers();
    run_vectors();
    random_round_trips(8);
    read_backpressure();
    write_backpressure();
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- test/ecc_vectors.txt
# name mask[38:0] correct_en byte_addr wdata exp_rdata exp_resp exp_single_cnt exp_multi_cnt
# All fields after the name are hex. Counters are running totals. Mask bits 38:32 hit check bits.
clean_lo      0000000000 1 00000000 12345678 12345678 0 0 0
clean_top     0000000000 1 000000FC FFFFFFFF FFFFFFFF 0 0 0
sbit_d0       0000000001 1 00000004 A5A5A5A5 A5A5A5A5 0 1 0
sbit_d31      0080000000 1 00000008 0F0F0F0F 0F0F0F0F 0 2 0
sbit_c0       0100000000 1 0000000C DEADBEEF DEADBEEF 0 3 0
sbit_c6       4000000000 1 00000010 00000000 00000000 0 4 0
nocorr_d4     0000000010 0 00000014 CAFEF00D CAFEF01D 0 5 0
nocorr_d20    0000100000 0 00000018 11111111 11011111 0 6 0
dbl_data      0000000003 1 0000001C 55555555 55555556 2 6 1
dbl_mix       0200000100 1 00000020 87654321 87654221 2 6 2
dbl_check     0300000000 1 00000024 0BADCAFE 0BADCAFE 2 6 3
dbl_nocorr    0000000081 0 00000028 F0F0F0F0 F0F0F071 2 6 4
clean_after   0000000000 1 0000002C 0000FFFF 0000FFFF 0 6 4
sbit_d15      0000008000 1 00000030 76543210 76543210 0 7 4

//--- vlog.f
common/ecc_pkg.sv
common/axil_pkg.sv
ecc/ecc_encode.sv
ecc/ecc_dec_fix.sv
design/ecc_ram.sv
design/axil_ecc_ctrl.sv
design/ecc_mem_top.sv
test/tb_ecc_mem.sv

//--- Bender.yml
package:
  name: ecc_mem

sources:
  # Packages first, then RTL bottom up.
  - common/ecc_pkg.sv
  - common/axil_pkg.sv
  - ecc/ecc_encode.sv
  - ecc/ecc_dec_fix.sv
  - design/ecc_ram.sv
  - design/axil_ecc_ctrl.sv
  - design/ecc_mem_top.sv
  - target: test
    files:
      - test/tb_ecc_mem.sv
